//--- rob.f
src/rob_pkg.sv
src/core_pkg.sv
src/rob_pointers.sv
src/rob_entry_table.sv
src/rob_data_store.sv
src/rob_commit.sv
src/rob.sv
tests/tb_rob.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_rob -f rob.f
	@out="$$(./obj_dir/Vtb_rob)"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- tests/tb_rob.sv
// Random traffic stays within full and two_free and only completes pending tickets; no flush
module tb_rob;
    timeunit 1ns;
    timeprecision 1ps;
    import rob_pkg::*;
    import core_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 16;
    localparam int FILL_CYCLES   = 12;
    localparam int DRAIN_CYCLES  = 60;
    localparam int TEST_CYCLES   = FILL_CYCLES + 3000 + DRAIN_CYCLES;

    // One model entry per allocated ticket with the oldest at the front
    typedef struct packed {
        rob_idx_t ticket;
        lreg_t    lreg;
        preg_t    preg, ppreg;
        pc_t      pc;
        word_t    data;
        cause_t   cause;
        logic     dest, done, has_data, exc;
    } entry_t;

    logic                         clk, rst_n, alloc_1, alloc_2, full, two_free;
    lreg_t    [1:0]               alloc_lreg, commit_lreg;
    preg_t    [1:0]               alloc_preg, alloc_ppreg, commit_preg, commit_ppreg;
    logic     [1:0]               alloc_dest, alloc_wait, commit_valid, commit_write;
    logic     [1:0]               commit_exc;
    pc_t      [1:0]               alloc_pc, commit_pc;
    word_t    [1:0]               commit_data;
    cause_t   [1:0]               commit_cause;
    rob_idx_t [1:0]               commit_ticket;
    rob_idx_t                     ticket;
    logic     [FU_PORTS-1:0]      upd_valid, upd_exc;
    rob_idx_t [FU_PORTS-1:0]      upd_ticket;
    word_t    [FU_PORTS-1:0]      upd_data;
    cause_t   [FU_PORTS-1:0]      upd_cause;
    rob_idx_t [OPERAND_PORTS-1:0] rd_ticket;
    word_t    [OPERAND_PORTS-1:0] rd_data;

    entry_t   model_q[$];
    rob_idx_t model_tail;
    integer   seed;
    int       errors;
    int       checks;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rob i_dut (.*);

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Head retires once complete and head+1 joins only when neither entry faulted
    function automatic logic [1:0] expected_retire(input entry_t q[$]);
        logic [1:0] r;
        r = 2'b00;
        if (q.size() > 0 && q[0].done) begin
            r[0] = 1'b1;
        end
        if (r[0] && !q[0].exc && q.size() > 1 && q[1].done && !q[1].exc) begin
            r[1] = 1'b1;
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    task automatic check_slot(input int s);
        entry_t m;
        string  ix;
        m  = model_q[s];
        ix = $sformatf("[%0d]", s);
        check_value({"commit_ticket", ix}, 32'(commit_ticket[s]), 32'(m.ticket));
        check_value({"commit_lreg", ix}, 32'(commit_lreg[s]), 32'(m.lreg));
        check_value({"commit_preg", ix}, 32'(commit_preg[s]), 32'(m.preg));
        check_value({"commit_ppreg", ix}, 32'(commit_ppreg[s]), 32'(m.ppreg));
        check_value({"commit_pc", ix}, commit_pc[s], m.pc);
        check_value({"commit_write", ix}, 32'(commit_write[s]), 32'(m.dest));
        check_value({"commit_exc", ix}, 32'(commit_exc[s]), 32'(m.exc));
        check_value({"commit_cause", ix}, 32'(commit_cause[s]), 32'(m.cause));
        if (m.dest) begin
            check_value({"commit_data", ix}, commit_data[s], m.data);
        end
    endtask

    // Inputs for one cycle chosen from the model state after the last edge
    task automatic drive_cycle(input bit allow_alloc, input bit allow_upd, input bit fill);
        int       n_alloc;
        int       pick;
        rob_idx_t cand[$];
        n_alloc = fill ? 2 : (allow_alloc ? rand_below(3) : 0);
        while (model_q.size() + n_alloc > ROB_ENTRIES) begin
            n_alloc--;
        end
        alloc_1 = (n_alloc == 1);
        alloc_2 = (n_alloc == 2);
        for (int s = 0; s < 2; s++) begin
            alloc_lreg[s]  = (fill || rand_below(4) != 0) ? lreg_t'(1 + rand_below(31)) : '0;
            alloc_dest[s]  = (alloc_lreg[s] != '0);
            alloc_wait[s]  = (rand_below(3) == 0);
            alloc_preg[s]  = preg_t'(rand_below(128));
            alloc_ppreg[s] = preg_t'(rand_below(128));
            alloc_pc[s]    = pc_t'($random(seed));
        end
        // Distinct pending tickets only with about one fault in eight
        upd_valid = '0;
        foreach (model_q[i]) begin
            if (!model_q[i].done) begin
                cand.push_back(model_q[i].ticket);
            end
        end
        for (int l = 0; l < FU_PORTS; l++) begin
            upd_ticket[l] = rob_idx_t'(rand_below(ROB_ENTRIES));
            upd_data[l]   = word_t'($random(seed));
            upd_exc[l]    = (rand_below(8) == 0);
            upd_cause[l]  = cause_t'(rand_below(16));
            if (allow_upd && cand.size() > 0 && rand_below(2) == 0) begin
                pick          = rand_below(cand.size());
                upd_ticket[l] = cand[pick];
                upd_valid[l]  = 1'b1;
                cand.delete(pick);
            end
        end
        for (int p = 0; p < OPERAND_PORTS; p++) begin
            rd_ticket[p] = rob_idx_t'(rand_below(ROB_ENTRIES));
        end
    endtask

    // Model moves on the same edge as the DUT by retiring, completing and then allocating
    always @(posedge clk) begin : model_update
        logic [1:0] ret;
        entry_t     e;
        if (rst_n) begin
            ret = expected_retire(model_q);
            repeat (int'(ret[0]) + int'(ret[1])) void'(model_q.pop_front());
            for (int l = 0; l < FU_PORTS; l++) begin
                foreach (model_q[j]) begin
                    if (upd_valid[l] && model_q[j].ticket == upd_ticket[l]) begin
                        e          = model_q[j];
                        e.done     = 1'b1;
                        e.has_data = 1'b1;
                        e.data     = upd_data[l];
                        e.exc      = upd_exc[l];
                        e.cause    = upd_cause[l];
                        model_q[j] = e;
                    end
                end
            end
            for (int s = 0; s < 2; s++) begin
                if ((s == 0 && (alloc_1 || alloc_2)) || (s == 1 && alloc_2)) begin
                    e          = '0;
                    e.ticket   = model_tail;
                    e.lreg     = alloc_lreg[s];
                    e.preg     = alloc_preg[s];
                    e.ppreg    = alloc_ppreg[s];
                    e.pc       = alloc_pc[s];
                    e.dest     = alloc_dest[s];
                    e.done     = !(alloc_wait[s] || alloc_lreg[s] != '0);
                    model_q.push_back(e);
                    model_tail = model_tail + rob_idx_t'(1);
                end
            end
        end
    end

    // Combinational outputs are settled by the falling edge
    always @(negedge clk) begin : compare_outputs
        logic [1:0] ret;
        if (rst_n) begin
            ret = expected_retire(model_q);
            check_value("commit_valid", 32'(commit_valid), 32'(ret));
            check_value("ticket", 32'(ticket), 32'(model_tail));
            check_value("full", 32'(full), 32'(model_q.size() == ROB_ENTRIES));
            check_value("two_free", 32'(two_free), 32'(model_q.size() < ROB_ENTRIES - 1));
            for (int s = 0; s < 2; s++) begin
                if (ret[s]) begin
                    check_slot(s);
                end else begin
                    // A slot that does not retire writes nothing
                    check_value($sformatf("commit_write[%0d]", s), 32'(commit_write[s]),
                                32'h0);
                end
            end
            for (int p = 0; p < OPERAND_PORTS; p++) begin
                foreach (model_q[j]) begin
                    if (model_q[j].has_data && model_q[j].ticket == rd_ticket[p]) begin
                        check_value($sformatf("rd_data[%0d]", p), rd_data[p], model_q[j].data);
                    end
                end
            end
        end
    end

    initial begin : main_sequence
        seed       = 32'heefa_ade5;
        errors     = 0;
        checks     = 0;
        model_tail = '0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        drive_cycle(1'b0, 1'b0, 1'b0);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Fill with pending entries, then random traffic, then drain with no allocation
        for (int c = 0; c < TEST_CYCLES; c++) begin
            @(posedge clk);
            #1;
            drive_cycle(c < TEST_CYCLES - DRAIN_CYCLES, c >= FILL_CYCLES, c < FILL_CYCLES);
        end
        @(posedge clk);
        #1;
        drive_cycle(1'b0, 1'b0, 1'b0);
        @(negedge clk);
        assert (model_q.size() == 0) else begin
            errors++;
            $display("Buffer still holds %0d entries after the drain phase", model_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(CLK_PERIOD * (RESET_CYCLES + TEST_CYCLES + 200));
        $display("Timeout: the run did not reach its end in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- src/rob.sv
// Dual-issue reorder buffer without flush or store handling; flow control is upstream only
module rob (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          alloc_1,
    input  logic                                          alloc_2,
    input  core_pkg::lreg_t   [1:0]                       alloc_lreg,
    input  core_pkg::preg_t   [1:0]                       alloc_preg,
    input  core_pkg::preg_t   [1:0]                       alloc_ppreg,
    input  logic              [1:0]                       alloc_dest,
    input  logic              [1:0]                       alloc_wait,
    input  core_pkg::pc_t     [1:0]                       alloc_pc,
    output rob_pkg::rob_idx_t                             ticket,
    output logic                                          full,
    output logic                                          two_free,
    input  logic              [rob_pkg::FU_PORTS-1:0]      upd_valid,
    input  rob_pkg::rob_idx_t [rob_pkg::FU_PORTS-1:0]      upd_ticket,
    input  core_pkg::word_t   [rob_pkg::FU_PORTS-1:0]      upd_data,
    input  logic              [rob_pkg::FU_PORTS-1:0]      upd_exc,
    input  core_pkg::cause_t  [rob_pkg::FU_PORTS-1:0]      upd_cause,
    input  rob_pkg::rob_idx_t [rob_pkg::OPERAND_PORTS-1:0] rd_ticket,
    output core_pkg::word_t   [rob_pkg::OPERAND_PORTS-1:0] rd_data,
    output logic              [1:0]                       commit_valid,
    output logic              [1:0]                       commit_write,
    output core_pkg::lreg_t   [1:0]                       commit_lreg,
    output core_pkg::preg_t   [1:0]                       commit_preg,
    output core_pkg::preg_t   [1:0]                       commit_ppreg,
    output core_pkg::word_t   [1:0]                       commit_data,
    output core_pkg::pc_t     [1:0]                       commit_pc,
    output logic              [1:0]                       commit_exc,
    output core_pkg::cause_t  [1:0]                       commit_cause,
    output rob_pkg::rob_idx_t [1:0]                       commit_ticket
);
    rob_pkg::rob_idx_t      head;
    logic                   retire_1;
    logic                   retire_2;
    logic             [1:0] head_valid;
    logic             [1:0] head_pending;
    logic             [1:0] head_exc;
    core_pkg::cause_t [1:0] head_cause;
    logic             [1:0] head_dest;
    core_pkg::lreg_t  [1:0] head_lreg;
    core_pkg::preg_t  [1:0] head_preg;
    core_pkg::preg_t  [1:0] head_ppreg;
    core_pkg::pc_t    [1:0] head_pc;
    core_pkg::word_t  [1:0] head_data;

    // Tail pointer doubles as the ticket handed to rename
    rob_pointers i_pointers (
        .clk      (clk),
        .rst_n    (rst_n),
        .alloc_1  (alloc_1),
        .alloc_2  (alloc_2),
        .retire_1 (retire_1),
        .retire_2 (retire_2),
        .head     (head),
        .tail     (ticket),
        .full     (full),
        .two_free (two_free)
    );

    rob_entry_table i_entry_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .tail         (ticket),
        .head         (head),
        .alloc_1      (alloc_1),
        .alloc_2      (alloc_2),
        .alloc_lreg   (alloc_lreg),
        .alloc_preg   (alloc_preg),
        .alloc_ppreg  (alloc_ppreg),
        .alloc_dest   (alloc_dest),
        .alloc_wait   (alloc_wait),
        .alloc_pc     (alloc_pc),
        .upd_valid    (upd_valid),
        .upd_ticket   (upd_ticket),
        .upd_exc      (upd_exc),
        .upd_cause    (upd_cause),
        .retire_1     (retire_1),
        .retire_2     (retire_2),
        .head_valid   (head_valid),
        .head_pending (head_pending),
        .head_exc     (head_exc),
        .head_cause   (head_cause),
        .head_dest    (head_dest),
        .head_lreg    (head_lreg),
        .head_preg    (head_preg),
        .head_ppreg   (head_ppreg),
        .head_pc      (head_pc)
    );

    rob_data_store i_data_store (
        .clk        (clk),
        .upd_valid  (upd_valid),
        .upd_ticket (upd_ticket),
        .upd_data   (upd_data),
        .rd_ticket  (rd_ticket),
        .head       (head),
        .rd_data    (rd_data),
        .head_data  (head_data)
    );

    rob_commit i_commit (
        .head          (head),
        .head_valid    (head_valid),
        .head_pending  (head_pending),
        .head_exc      (head_exc),
        .head_cause    (head_cause),
        .head_dest     (head_dest),
        .head_lreg     (head_lreg),
        .head_preg     (head_preg),
        .head_ppreg    (head_ppreg),
        .head_pc       (head_pc),
        .head_data     (head_data),
        .retire_1      (retire_1),
        .retire_2      (retire_2),
        .commit_valid  (commit_valid),
        .commit_write  (commit_write),
        .commit_lreg   (commit_lreg),
        .commit_preg   (commit_preg),
        .commit_ppreg  (commit_ppreg),
        .commit_data   (commit_data),
        .commit_pc     (commit_pc),
        .commit_exc    (commit_exc),
        .commit_cause  (commit_cause),
        .commit_ticket (commit_ticket)
    );

endmodule

//--- src/rob_commit.sv
// Faulting entries retire alone in slot 0; nothing here is registered
module rob_commit (
    input  rob_pkg::rob_idx_t       head,
    input  logic             [1:0]  head_valid,
    input  logic             [1:0]  head_pending,
    input  logic             [1:0]  head_exc,
    input  core_pkg::cause_t [1:0]  head_cause,
    input  logic             [1:0]  head_dest,
    input  core_pkg::lreg_t  [1:0]  head_lreg,
    input  core_pkg::preg_t  [1:0]  head_preg,
    input  core_pkg::preg_t  [1:0]  head_ppreg,
    input  core_pkg::pc_t    [1:0]  head_pc,
    input  core_pkg::word_t  [1:0]  head_data,
    output logic                    retire_1,
    output logic                    retire_2,
    output logic             [1:0]  commit_valid,
    output logic             [1:0]  commit_write,
    output core_pkg::lreg_t  [1:0]  commit_lreg,
    output core_pkg::preg_t  [1:0]  commit_preg,
    output core_pkg::preg_t  [1:0]  commit_ppreg,
    output core_pkg::word_t  [1:0]  commit_data,
    output core_pkg::pc_t    [1:0]  commit_pc,
    output logic             [1:0]  commit_exc,
    output core_pkg::cause_t [1:0]  commit_cause,
    output rob_pkg::rob_idx_t [1:0] commit_ticket
);
    import rob_pkg::*;

    logic [1:0] done;
    rob_idx_t   head_nxt;

    // An entry is done once allocated and no longer waiting on execute
    assign done = head_valid & ~head_pending;

    assign retire_1 = done[0];

    // Second slot needs a clean head and must not carry a fault itself
    assign retire_2 = retire_1 & ~head_exc[0] & done[1] & ~head_exc[1];

    assign head_nxt = head + rob_idx_t'(1);

    assign commit_valid  = {retire_2, retire_1};
    assign commit_write  = commit_valid & head_dest;
    assign commit_exc    = head_exc;
    assign commit_cause  = head_cause;
    assign commit_lreg   = head_lreg;
    assign commit_preg   = head_preg;
    assign commit_ppreg  = head_ppreg;
    assign commit_pc     = head_pc;
    assign commit_data   = head_data;
    assign commit_ticket = {head_nxt, head};

endmodule

//--- src/rob_data_store.sv
// Write lanes must carry distinct tickets; reads return the value as of the last edge
module rob_data_store (
    input  logic                                          clk,
    input  logic              [rob_pkg::FU_PORTS-1:0]      upd_valid,
    input  rob_pkg::rob_idx_t [rob_pkg::FU_PORTS-1:0]      upd_ticket,
    input  core_pkg::word_t   [rob_pkg::FU_PORTS-1:0]      upd_data,
    input  rob_pkg::rob_idx_t [rob_pkg::OPERAND_PORTS-1:0] rd_ticket,
    input  rob_pkg::rob_idx_t                             head,
    output core_pkg::word_t   [rob_pkg::OPERAND_PORTS-1:0] rd_data,
    output core_pkg::word_t   [1:0]                       head_data
);
    import rob_pkg::*;
    import core_pkg::*;

    word_t    mem [ROB_ENTRIES];
    rob_idx_t head_nxt;

    // One write per functional unit lane
    always_ff @(posedge clk) begin
        for (int i = 0; i < FU_PORTS; i++) begin
            if (upd_valid[i]) begin
                mem[upd_ticket[i]] <= upd_data[i];
            end
        end
    end

    // Operand reads toward rename
    always_comb begin
        for (int p = 0; p < OPERAND_PORTS; p++) begin
            rd_data[p] = mem[rd_ticket[p]];
        end
    end

    // Commit data for both retire slots
    assign head_nxt     = head + rob_idx_t'(1);
    assign head_data[0] = mem[head];
    assign head_data[1] = mem[head_nxt];

endmodule

//--- src/rob_entry_table.sv
// Updates must name allocated, pending entries with distinct tickets per cycle; no flush support
module rob_entry_table (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  rob_pkg::rob_idx_t                       tail,
    input  rob_pkg::rob_idx_t                       head,
    input  logic                                    alloc_1,
    input  logic                                    alloc_2,
    input  core_pkg::lreg_t  [1:0]                  alloc_lreg,
    input  core_pkg::preg_t  [1:0]                  alloc_preg,
    input  core_pkg::preg_t  [1:0]                  alloc_ppreg,
    input  logic             [1:0]                  alloc_dest,
    input  logic             [1:0]                  alloc_wait,
    input  core_pkg::pc_t    [1:0]                  alloc_pc,
    input  logic             [rob_pkg::FU_PORTS-1:0] upd_valid,
    input  rob_pkg::rob_idx_t [rob_pkg::FU_PORTS-1:0] upd_ticket,
    input  logic             [rob_pkg::FU_PORTS-1:0] upd_exc,
    input  core_pkg::cause_t [rob_pkg::FU_PORTS-1:0] upd_cause,
    input  logic                                    retire_1,
    input  logic                                    retire_2,
    output logic             [1:0]                  head_valid,
    output logic             [1:0]                  head_pending,
    output logic             [1:0]                  head_exc,
    output core_pkg::cause_t [1:0]                  head_cause,
    output logic             [1:0]                  head_dest,
    output core_pkg::lreg_t  [1:0]                  head_lreg,
    output core_pkg::preg_t  [1:0]                  head_preg,
    output core_pkg::preg_t  [1:0]                  head_ppreg,
    output core_pkg::pc_t    [1:0]                  head_pc
);
    import rob_pkg::*;
    import core_pkg::*;

    logic [ROB_ENTRIES-1:0] valid_q;
    logic [ROB_ENTRIES-1:0] pending_q;
    logic [ROB_ENTRIES-1:0] exc_q;
    logic [ROB_ENTRIES-1:0] dest_q;
    cause_t                 cause_q [ROB_ENTRIES];
    lreg_t                  lreg_q  [ROB_ENTRIES];
    preg_t                  preg_q  [ROB_ENTRIES];
    preg_t                  ppreg_q [ROB_ENTRIES];
    pc_t                    pc_q    [ROB_ENTRIES];

    rob_idx_t [1:0] tail_idx;
    rob_idx_t [1:0] head_idx;
    logic     [1:0] alloc_en;
    logic     [1:0] retire_en;

    // Slot 0 sits at the pointer, slot 1 right after it
    assign tail_idx[0] = tail;
    assign tail_idx[1] = tail + rob_idx_t'(1);
    assign head_idx[0] = head;
    assign head_idx[1] = head + rob_idx_t'(1);

    assign alloc_en  = {alloc_2, alloc_1 | alloc_2};
    assign retire_en = {retire_2, retire_1};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (retire_en[s]) begin
                    valid_q[head_idx[s]] <= 1'b0;
                end
            end
            for (int s = 0; s < 2; s++) begin
                if (alloc_en[s]) begin
                    valid_q[tail_idx[s]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        // Completion clears pending and latches the exception
        for (int i = 0; i < FU_PORTS; i++) begin
            if (upd_valid[i]) begin
                pending_q[upd_ticket[i]] <= 1'b0;
                exc_q[upd_ticket[i]]     <= upd_exc[i];
                cause_q[upd_ticket[i]]   <= upd_cause[i];
            end
        end
        // Entries with no result to wait for are complete on arrival
        for (int s = 0; s < 2; s++) begin
            if (alloc_en[s]) begin
                pending_q[tail_idx[s]] <= alloc_wait[s] || (alloc_lreg[s] != '0);
                exc_q[tail_idx[s]]     <= 1'b0;
                cause_q[tail_idx[s]]   <= '0;
                dest_q[tail_idx[s]]    <= alloc_dest[s];
                lreg_q[tail_idx[s]]    <= alloc_lreg[s];
                preg_q[tail_idx[s]]    <= alloc_preg[s];
                ppreg_q[tail_idx[s]]   <= alloc_ppreg[s];
                pc_q[tail_idx[s]]      <= alloc_pc[s];
            end
        end
    end

    // Head and head+1 view for the commit logic
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            head_valid[s]   = valid_q[head_idx[s]];
            head_pending[s] = pending_q[head_idx[s]];
            head_exc[s]     = exc_q[head_idx[s]];
            head_cause[s]   = cause_q[head_idx[s]];
            head_dest[s]    = dest_q[head_idx[s]];
            head_lreg[s]    = lreg_q[head_idx[s]];
            head_preg[s]    = preg_q[head_idx[s]];
            head_ppreg[s]   = ppreg_q[head_idx[s]];
            head_pc[s]      = pc_q[head_idx[s]];
        end
    end

    // Execute may only complete work that rename handed out and that is still waiting
    for (genvar g = 0; g < FU_PORTS; g++) begin : g_upd_chk
        a_upd_live: assert property (@(posedge clk) disable iff (!rst_n)
            upd_valid[g] |-> valid_q[upd_ticket[g]] && pending_q[upd_ticket[g]])
            else $error("lane %0d updates a free or completed ticket", g);

        for (genvar h = g + 1; h < FU_PORTS; h++) begin : g_pair
            a_upd_distinct: assert property (@(posedge clk) disable iff (!rst_n)
                upd_valid[g] && upd_valid[h] |-> upd_ticket[g] != upd_ticket[h])
                else $error("lanes %0d and %0d share a ticket", g, h);
        end
    end

endmodule

//--- src/rob_pointers.sv
// Producer must respect full and two_free; alloc_2 takes two entries whether or not alloc_1 is set
module rob_pointers (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_1,
    input  logic              alloc_2,
    input  logic              retire_1,
    input  logic              retire_2,
    output rob_pkg::rob_idx_t head,
    output rob_pkg::rob_idx_t tail,
    output logic              full,
    output logic              two_free
);
    import rob_pkg::*;

    rob_cnt_t count;
    rob_cnt_t alloc_cnt;
    rob_cnt_t retire_cnt;

    // Entries taken and released this cycle
    always_comb begin
        if (alloc_2) begin
            alloc_cnt = rob_cnt_t'(2);
        end else if (alloc_1) begin
            alloc_cnt = rob_cnt_t'(1);
        end else begin
            alloc_cnt = '0;
        end
    end

    assign retire_cnt = rob_cnt_t'(retire_1) + rob_cnt_t'(retire_2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Pointers wrap at the entry count
            tail  <= tail + alloc_cnt[ROB_IDX_W-1:0];
            head  <= head + retire_cnt[ROB_IDX_W-1:0];
            count <= count + alloc_cnt - retire_cnt;
        end
    end

    // Flags come from the registered count only
    assign full     = (count == rob_cnt_t'(ROB_ENTRIES));
    assign two_free = (count < rob_cnt_t'(ROB_ENTRIES - 1));

    // Rename must never allocate into occupied entries
    a_alloc_one_room: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_1 && !alloc_2 |-> !full)
        else $error("alloc_1 while buffer full");

    a_alloc_two_room: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_2 |-> two_free)
        else $error("alloc_2 without two free entries");

    // Second slot retires only behind the head
    a_retire_order: assert property (@(posedge clk) disable iff (!rst_n)
        retire_2 |-> retire_1)
        else $error("retire_2 without retire_1");

endmodule

//--- src/core_pkg.sv
// Widths follow a 32-bit integer core; lreg 0 is the zero register and means no write
package core_pkg;

    // Integer datapath width
    localparam int XLEN = 32;

    // Register file sizes and exception code width
    localparam int LREG_W  = 5;
    localparam int PREG_W  = 7;
    localparam int CAUSE_W = 4;

    // Result word as produced by execute and stored in the buffer
    typedef logic [XLEN-1:0] word_t;

    // Instruction address carried to commit
    typedef logic [XLEN-1:0] pc_t;

    // Architectural register number
    typedef logic [LREG_W-1:0] lreg_t;

    // Physical register number from the rename free list
    typedef logic [PREG_W-1:0] preg_t;

    // Exception code recorded at completion
    typedef logic [CAUSE_W-1:0] cause_t;

endpackage

//--- src/rob_pkg.sv
// Entry count must be a power of two so tickets wrap naturally at the top of the buffer
package rob_pkg;

    // Buffer depth and the ticket width that indexes it
    localparam int ROB_ENTRIES = 16;
    localparam int ROB_IDX_W   = $clog2(ROB_ENTRIES);

    // Result write ports from the functional units
    localparam int FU_PORTS = 4;

    // Operand read ports toward rename for two sources per issued instruction
    localparam int OPERAND_PORTS = 4;

    // Position of an entry in the buffer, handed out at allocation
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // Live entry count with one extra bit so a full buffer is representable
    typedef logic [ROB_IDX_W:0] rob_cnt_t;

endpackage
